//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Fetching this address ends the run and drops active
`define MIPS_HALT_ADDR 32'h0000_0000

// Size of the general purpose register file
`define MIPS_NREGS 32

`endif

//--- verilog/mips_isa_pkg.sv
package mips_isa_pkg;

  // Register format, used by ADDU, SUBU, AND, OR, XOR, SLT, SLL and JR
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_form_t;

  // Immediate format for ALU immediates, loads, stores and branches
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_form_t;

  // Jump format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } j_form_t;

  // One fetched word, viewed through whichever format the opcode calls for
  typedef union packed {
    r_form_t r;
    i_form_t i;
    j_form_t j;
  } instr_u;

  // Primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_ORI     = 6'h0D;
  localparam logic [5:0] OP_LUI     = 6'h0F;
  localparam logic [5:0] OP_LW      = 6'h23;
  localparam logic [5:0] OP_SW      = 6'h2B;

  // Function codes under OP_SPECIAL
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2A;

endpackage

//--- verilog/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  typedef logic [2:0] alu_op_t;
  typedef logic       wb_sel_t;
  typedef logic [1:0] pc_src_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLT = 3'd5;
  localparam alu_op_t ALU_SLL = 3'd6;
  localparam alu_op_t ALU_LUI = 3'd7;

  localparam wb_sel_t WB_ALU = 1'b0;
  localparam wb_sel_t WB_MEM = 1'b1;

  localparam pc_src_t PC_SEQ    = 2'd0;
  localparam pc_src_t PC_BRANCH = 2'd1;
  localparam pc_src_t PC_JUMP   = 2'd2;
  localparam pc_src_t PC_JR     = 2'd3;

endpackage

//--- verilog/mips_ctrl_if.sv
`timescale 1ns/1ns

interface mips_ctrl_if;
  import mips_ctrl_pkg::*;

  alu_op_t alu_op;
  logic    alu_src_imm;
  logic    imm_zero_ext;
  logic    reg_write;
  logic    reg_dst_rd;
  wb_sel_t wb_sel;
  pc_src_t pc_src;
  logic    branch_ne;
  logic    mem_read;
  logic    mem_write;

  modport decoder (
    output alu_op, alu_src_imm, imm_zero_ext, reg_write, reg_dst_rd,
    output wb_sel, pc_src, branch_ne, mem_read, mem_write
  );

  modport alu (input alu_op, alu_src_imm, imm_zero_ext, pc_src, branch_ne);

  modport pc (input pc_src);

endinterface

//--- verilog/mips_decoder.sv
`timescale 1ns/1ns

module mips_decoder (
  input mips_isa_pkg::instr_u instr,
  mips_ctrl_if.decoder        ctrl
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  always_comb
  begin
    // Anything not matched below behaves as a NOP
    ctrl.alu_op       = ALU_ADD;
    ctrl.alu_src_imm  = 1'b0;
    ctrl.imm_zero_ext = 1'b0;
    ctrl.reg_write    = 1'b0;
    ctrl.reg_dst_rd   = 1'b0;
    ctrl.wb_sel       = WB_ALU;
    ctrl.pc_src       = PC_SEQ;
    ctrl.branch_ne    = 1'b0;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;

    case (instr.r.opcode)
      OP_SPECIAL:
      begin
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_write  = 1'b1;
        case (instr.r.funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLL:  ctrl.alu_op = ALU_SLL;
          FN_JR:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.pc_src    = PC_JR;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDIU:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      OP_ORI:
      begin
        ctrl.alu_op       = ALU_OR;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.reg_write    = 1'b1;
      end
      OP_LUI:
      begin
        ctrl.alu_op    = ALU_LUI;
        ctrl.reg_write = 1'b1;
      end
      OP_LW:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = WB_MEM;
        ctrl.mem_read    = 1'b1;
      end
      OP_SW:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: ctrl.pc_src = PC_BRANCH;
      OP_BNE:
      begin
        ctrl.pc_src    = PC_BRANCH;
        ctrl.branch_ne = 1'b1;
      end
      OP_J: ctrl.pc_src = PC_JUMP;
      default: ;
    endcase
  end

endmodule

//--- verilog/mips_regfile.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic        write_en,
  input  logic [31:0] write_data,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);

  logic [31:0] regs [`MIPS_NREGS];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_NREGS; i++)
        regs[i] <= '0;
    end
    else if (clk_enable && write_en && rd_addr != 5'd0)
    begin
      regs[rd_addr] <= write_data;
    end
  end

  // $zero reads as 0 regardless of array contents
  assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
  assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

  // v0 tap for the testbench
  assign register_v0 = regs[2];

endmodule

//--- verilog/mips_alu.sv
`timescale 1ns/1ns

module mips_alu (
  input  mips_isa_pkg::instr_u instr,
  mips_ctrl_if.alu             ctrl,
  input  logic [31:0]          rs_data,
  input  logic [31:0]          rt_data,
  output logic [31:0]          result,
  output logic                 take_branch
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  logic [31:0] imm_ext;
  logic [31:0] operand_b;

  // ORI zero-extends, everything else sign-extends
  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm16}
                                     : {{16{instr.i.imm16[15]}}, instr.i.imm16};

  assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  always_comb
  begin
    case (ctrl.alu_op)
      ALU_ADD: result = rs_data + operand_b;
      ALU_SUB: result = rs_data - operand_b;
      ALU_AND: result = rs_data & operand_b;
      ALU_OR:  result = rs_data | operand_b;
      ALU_XOR: result = rs_data ^ operand_b;
      ALU_SLT: result = {31'd0, $signed(rs_data) < $signed(operand_b)};
      // SLL shifts rt by the shamt field
      ALU_SLL: result = operand_b << instr.r.shamt;
      ALU_LUI: result = {instr.i.imm16, 16'h0000};
      default: result = '0;
    endcase
  end

  // BEQ on equality, BNE on inequality
  assign take_branch = ((rs_data == rt_data) ^ ctrl.branch_ne)
                       && (ctrl.pc_src == PC_BRANCH);

endmodule

//--- verilog/mips_pc_unit.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_pc_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clk_enable,
  input  mips_isa_pkg::instr_u instr,
  mips_ctrl_if.pc              ctrl,
  input  logic                 take_branch,
  input  logic [31:0]          rs_data,
  output logic [31:0]          pc,
  output logic                 active
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  logic [31:0] pc_plus4;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] target;
  logic        redirect;
  logic        pending;
  logic [31:0] pending_target;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.target26, 2'b00};

  always_comb
  begin
    case (ctrl.pc_src)
      PC_JUMP: target = jump_target;
      PC_JR:   target = rs_data;
      default: target = branch_target;
    endcase
  end

  assign redirect = take_branch || ctrl.pc_src == PC_JUMP || ctrl.pc_src == PC_JR;

  // The delay slot runs first, the stored target follows one cycle later
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= `MIPS_RESET_VECTOR;
      pending <= 1'b0;
    end
    else if (clk_enable)
    begin
      pc      <= pending ? pending_target : pc_plus4;
      pending <= redirect;
    end
  end

  always_ff @(posedge clk)
  begin
    if (clk_enable && redirect)
      pending_target <= target;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b1;
    else if (clk_enable && pc == `MIPS_HALT_ADDR)
      active <= 1'b0;
  end

endmodule

//--- verilog/mips_cpu_harvard.sv
`timescale 1ns/1ns

module mips_cpu_harvard (
  // Standard signals
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  // Global stall when low
  input  logic        clk_enable,

  // Instruction port, combinational read
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  // Data port, combinational read and single-cycle write
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  instr_u      instr;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_result;
  logic        take_branch;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  assign instr = instr_readdata;

  mips_ctrl_if u_ctrl ();

  mips_decoder u_decoder (
    .instr (instr),
    .ctrl  (u_ctrl.decoder)
  );

  // Write-back destination and source
  assign wb_addr = u_ctrl.reg_dst_rd ? instr.r.rd : instr.r.rt;
  assign wb_data = (u_ctrl.wb_sel == WB_MEM) ? data_readdata : alu_result;

  mips_regfile u_regfile (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .rs_addr     (instr.r.rs),
    .rt_addr     (instr.r.rt),
    .rd_addr     (wb_addr),
    .write_en    (u_ctrl.reg_write),
    .write_data  (wb_data),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .register_v0 (register_v0)
  );

  mips_alu u_alu (
    .instr       (instr),
    .ctrl        (u_ctrl.alu),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  mips_pc_unit u_pc_unit (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .instr       (instr),
    .ctrl        (u_ctrl.pc),
    .take_branch (take_branch),
    .rs_data     (rs_data),
    .pc          (instr_address),
    .active      (active)
  );

  // Loads and stores address through the ALU sum
  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_read      = u_ctrl.mem_read;
  assign data_write     = u_ctrl.mem_write;

endmodule

//--- bench/mips_asserts.sv
`timescale 1ns/1ns

module mips_asserts (
  input logic        clk,
  input logic        reset,
  input logic        active,
  input logic        data_read,
  input logic        data_write,
  input logic [31:0] instr_address
);

  // A single instruction is either a load or a store
  assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
    else $error("data_read and data_write both high");

  assert property (@(posedge clk) disable iff (reset) instr_address[1:0] == 2'b00)
    else $error("instr_address not word aligned");

  // Core comes out of reset running
  assert property (@(posedge clk) reset |=> active)
    else $error("active low on the cycle after reset");

endmodule

bind mips_cpu_harvard mips_asserts u_asserts (
  .clk           (clk),
  .reset         (reset),
  .active        (active),
  .data_read     (data_read),
  .data_write    (data_write),
  .instr_address (instr_address)
);

//--- bench/mips_tb.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_tb;
  import mips_isa_pkg::*;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  logic [31:0] prog [256];
  logic [31:0] prog2 [256];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_dmem [64];
  logic [31:0] imem_off;
  logic [31:0] lfsr;
  logic [31:0] saved_pc;
  logic [31:0] saved_v0;
  logic [31:0] exp_v0;
  int          plen;
  int          plen2;
  int          cycles;
  int          limit;
  int          checks;
  int          errors;
  int          tests;
  int          errors_before;
  logic        hold_check;

  mips_cpu_harvard u_dut (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #5 clk = ~clk;

  // Instruction memory sits at the reset vector, everything else reads as NOP
  assign imem_off       = instr_address - `MIPS_RESET_VECTOR;
  assign instr_readdata = (imem_off < 32'd1024) ? imem[imem_off[9:2]] : 32'h0;

  // Data port returns a poison word unless the read strobe is up
  assign data_readdata  = data_read ? dmem[data_address[7:2]] : 32'hBAD0_BAD0;

  always @(posedge clk)
  begin
    if (clk_enable && data_write)
      dmem[data_address[7:2]] <= data_writedata;
  end

  // Run limit grows with every program loaded
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("Timeout after %0d cycles, the core never reached the halt address", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Random enable drops, checking that state holds across each one
  always @(negedge clk)
  begin
    if (hold_check && !clk_enable)
    begin
      check_word("instr_address", saved_pc, instr_address);
      check_word("register_v0", saved_v0, register_v0);
    end
    saved_pc = instr_address;
    saved_v0 = register_v0;
    if (hold_check)
      clk_enable <= (rand_bits(2) != 0);
    else
      clk_enable <= 1'b1;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] r_ins(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                        logic [4:0] rt, logic [4:0] sh);
    return {OP_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] i_ins(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_ins(logic [31:0] addr);
    return {OP_J, addr[27:2]};
  endfunction

  task automatic emit(logic [31:0] word);
    prog[plen] = word;
    plen++;
  endtask

  task automatic clear_prog();
    for (int k = 0; k < 256; k++)
      prog[k] = 32'h0;
    plen = 0;
  endtask

  function automatic logic [31:0] prog_word(logic [31:0] addr);
    logic [31:0] off;
    off = addr - `MIPS_RESET_VECTOR;
    return (off < 32'd1024) ? prog[off[9:2]] : 32'h0;
  endfunction

  // Instruction-level model with one delay slot per branch or jump
  function automatic logic [31:0] ref_run();
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] val;
    logic [4:0]  dst;
    instr_u      w;
    int          steps;
    for (int k = 0; k < 32; k++)
      ref_regs[k] = 32'h0;
    pc = `MIPS_RESET_VECTOR;
    npc = pc + 4;
    steps = 0;
    while (pc != `MIPS_HALT_ADDR && steps < 1000)
    begin
      w = prog_word(pc);
      a = ref_regs[w.r.rs];
      b = ref_regs[w.r.rt];
      sext = {{16{w.i.imm16[15]}}, w.i.imm16};
      nn = npc + 4;
      dst = 5'd0;
      val = 32'h0;
      case (w.r.opcode)
        OP_SPECIAL:
        begin
          dst = w.r.rd;
          case (w.r.funct)
            FN_ADDU: val = a + b;
            FN_SUBU: val = a - b;
            FN_AND:  val = a & b;
            FN_OR:   val = a | b;
            FN_XOR:  val = a ^ b;
            FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLL:  val = b << w.r.shamt;
            FN_JR:
            begin
              dst = 5'd0;
              nn = a;
            end
            default: dst = 5'd0;
          endcase
        end
        OP_ADDIU:
        begin
          dst = w.i.rt;
          val = a + sext;
        end
        OP_ORI:
        begin
          dst = w.i.rt;
          val = a | {16'h0, w.i.imm16};
        end
        OP_LUI:
        begin
          dst = w.i.rt;
          val = {w.i.imm16, 16'h0};
        end
        OP_LW:
        begin
          dst = w.i.rt;
          val = ref_dmem[(a + sext) >> 2 & 32'h3F];
        end
        OP_SW: ref_dmem[(a + sext) >> 2 & 32'h3F] = b;
        OP_BEQ: if (a == b) nn = npc + (sext << 2);
        OP_BNE: if (a != b) nn = npc + (sext << 2);
        OP_J:   nn = {npc[31:28], w.j.target26, 2'b00};
        default: ;
      endcase
      if (dst != 5'd0)
        ref_regs[dst] = val;
      pc = npc;
      npc = nn;
      steps++;
    end
    return ref_regs[2];
  endfunction

  task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (expected === actual)
    else
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report(string name);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "errors");
    errors_before = errors;
  endtask

  task automatic load_and_reset();
    for (int k = 0; k < 256; k++)
      imem[k] = prog[k];
    // Fill depends on the full byte address
    for (int k = 0; k < 64; k++)
    begin
      dmem[k] = 32'hD00D_0000 ^ (k * 4);
      ref_dmem[k] = 32'hD00D_0000 ^ (k * 4);
    end
    limit += plen * 4;
    @(negedge clk);
    reset <= 1'b1;
    repeat (4) @(negedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_program(string name, logic stall, int nwords);
    load_and_reset();
    exp_v0 = ref_run();
    @(posedge clk);
    hold_check = stall;
    while (active === 1'b1)
      @(negedge clk);
    @(posedge clk);
    hold_check = 1'b0;
    @(negedge clk);
    check_word("register_v0", exp_v0, register_v0);
    for (int k = 0; k < nwords; k++)
      check_word($sformatf("dmem[%0d]", k), ref_dmem[k], dmem[k]);
    report(name);
  endtask

  task automatic build_alu_program();
    clear_prog();
    emit(32'h0);
    for (int r = 8; r < 14; r++)
    begin
      emit(i_ins(OP_LUI, r, 0, rand_bits(16)));
      emit(i_ins(OP_ORI, r, r, rand_bits(16)));
    end
    emit(i_ins(OP_ADDIU, 14, 0, rand_bits(16)));
    emit(r_ins(FN_ADDU, 2, 8, 9, 0));
    emit(r_ins(FN_SUBU, 2, 2, 10, 0));
    emit(r_ins(FN_AND, 15, 2, 11, 0));
    emit(r_ins(FN_OR, 2, 15, 12, 0));
    emit(r_ins(FN_XOR, 2, 2, 13, 0));
    emit(r_ins(FN_SLT, 16, 2, 14, 0));
    emit(r_ins(FN_SLL, 17, 0, 2, rand_bits(5)));
    emit(r_ins(FN_ADDU, 2, 17, 16, 0));
    emit(r_ins(FN_JR, 0, 0, 0, 0));
    emit(32'h0);
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    clk_enable = 1'b1;
    lfsr = 32'd3;
    cycles = 0;
    limit = 200;
    checks = 0;
    errors = 0;
    tests = 0;
    errors_before = 0;
    hold_check = 1'b0;

    build_alu_program();
    prog2 = prog;
    plen2 = plen;
    load_and_reset();
    check_word("instr_address", `MIPS_RESET_VECTOR, instr_address);
    check_word("active", 32'd1, {31'd0, active});
    check_word("data_read", 32'd0, {31'd0, data_read});
    check_word("data_write", 32'd0, {31'd0, data_write});
    report("reset state");

    run_program("alu chain", 1'b0, 0);

    // Store and load round trip
    clear_prog();
    emit(32'h0);
    for (int r = 10; r < 14; r++)
    begin
      emit(i_ins(OP_LUI, r, 0, rand_bits(16)));
      emit(i_ins(OP_ORI, r, r, rand_bits(16)));
      emit(i_ins(OP_SW, r, 0, (r - 10) * 4));
    end
    emit(i_ins(OP_LW, 14, 0, 16'd4));
    emit(i_ins(OP_LW, 15, 0, 16'd12));
    emit(r_ins(FN_SUBU, 2, 14, 15, 0));
    emit(i_ins(OP_SW, 2, 0, 16'd16));
    emit(r_ins(FN_JR, 0, 0, 0, 0));
    emit(32'h0);
    run_program("load store", 1'b0, 6);

    // Taken and untaken branches, each delay slot touching v0
    clear_prog();
    emit(32'h0);
    emit(i_ins(OP_ADDIU, 8, 0, 16'd5));
    emit(i_ins(OP_ADDIU, 9, 0, 16'd5));
    emit(i_ins(OP_ADDIU, 10, 0, 16'd7));
    emit(i_ins(OP_BEQ, 9, 8, 16'd2));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0001));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0010));
    emit(i_ins(OP_BNE, 9, 8, 16'd2));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0100));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h1000));
    emit(i_ins(OP_BEQ, 10, 8, 16'd2));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0200));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h2000));
    emit(i_ins(OP_BNE, 10, 8, 16'd2));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0400));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h4000));
    emit(r_ins(FN_JR, 0, 0, 0, 0));
    emit(32'h0);
    run_program("branches", 1'b0, 0);

    // Call through J, return through JR $31
    clear_prog();
    emit(32'h0);
    emit(i_ins(OP_LUI, 31, 0, 16'hBFC0));
    emit(i_ins(OP_ORI, 31, 31, 16'd20));
    emit(j_ins(`MIPS_RESET_VECTOR + 64));
    emit(i_ins(OP_ADDIU, 2, 0, 16'd3));
    emit(i_ins(OP_ADDIU, 2, 2, 16'h0040));
    emit(r_ins(FN_JR, 0, 0, 0, 0));
    emit(32'h0);
    plen = 16;
    emit(r_ins(FN_SLL, 2, 0, 2, 5'd4));
    emit(r_ins(FN_JR, 0, 31, 0, 0));
    emit(i_ins(OP_ADDIU, 2, 2, 16'd1));
    run_program("jump and return", 1'b0, 0);

    prog = prog2;
    plen = plen2;
    run_program("alu chain with stalls", 1'b1, 0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- mips_cpu.f
+incdir+include
verilog/mips_isa_pkg.sv
verilog/mips_ctrl_pkg.sv
verilog/mips_ctrl_if.sv
verilog/mips_decoder.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_pc_unit.sv
verilog/mips_cpu_harvard.sv
bench/mips_asserts.sv
bench/mips_tb.sv
